/* Makefile */
# Verilator simulation of the VLIW core

LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench, run it and search the log for the pass message"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module vliw_tb -Mdir obj_dir -o vliw_sim
	./obj_dir/vliw_sim | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* common/vliw_pkg.sv */
// VLIW datapath shared types
// Data word, operand address, slot bundles, slot writes and the
// fixed indices of the special registers and result banks

package vliw_pkg;

   // 27-bit two's-complement data
   typedef logic signed [26:0] word_t;

   // Top two bits pick a bank, low eight an entry
   typedef struct packed {
      logic [1:0] bank;
      logic [7:0] index;
   } addr_t;

   typedef struct packed {
      word_t re;
      word_t im;
   } z_t;

   //==================================================
   // Slot bundles
   //==================================================

   typedef struct packed {
      logic  en;
      word_t value;
      addr_t dest;
   } load_op_t;

   typedef struct packed {
      logic  en;
      addr_t src;
      addr_t dest;
   } neg_op_t;

   // Shared by add and multiply
   typedef struct packed {
      logic  en;
      addr_t src1;
      addr_t src2;
      addr_t dest;
   } bin_op_t;

   // One slot's write into its bank and the special registers
   typedef struct packed {
      logic       en;
      logic [7:0] index;
      word_t      data;
   } wr_t;

   //==================================================
   // Fixed indices
   //==================================================

   localparam logic [7:0] IDX_Z_RE = 8'd0;
   localparam logic [7:0] IDX_Z_IM = 8'd1;
   localparam logic [7:0] IDX_MAG  = 8'd2;

   localparam logic [1:0] BANK_LOAD = 2'd0;
   localparam logic [1:0] BANK_NEG  = 2'd1;
   localparam logic [1:0] BANK_ADD  = 2'd2;
   localparam logic [1:0] BANK_MUL  = 2'd3;

   localparam int NUM_RD = 5;

   localparam int PORT_NEG  = 0;
   localparam int PORT_ADD1 = 1;
   localparam int PORT_ADD2 = 2;
   localparam int PORT_MUL1 = 3;
   localparam int PORT_MUL2 = 4;

endpackage

/* hw/exec_slots.sv */
// Execution slots
// Load passes its value, negate and multiply are combinational and add
// has one pipe stage. Each slot produces one write per cycle.

module exec_slots
   import vliw_pkg::*;
(
   input  logic     clk,
   input  logic     reset,
   input  load_op_t load_op,
   input  neg_op_t  neg_op,
   input  bin_op_t  add_op,
   input  bin_op_t  mul_op,
   input  word_t    operand [NUM_RD],
   output wr_t      load_wr,
   output wr_t      neg_wr,
   output wr_t      add_wr,
   output wr_t      mul_wr
);

   logic              add_valid;
   logic [7:0]        add_index;
   word_t             add_sum;
   logic signed [53:0] product;

   // Destination bank bits are ignored, the slot owns its bank
   assign load_wr = '{en: load_op.en, index: load_op.dest.index, data: load_op.value};

   // Wraps on the most negative value
   assign neg_wr = '{en: neg_op.en, index: neg_op.dest.index, data: -operand[PORT_NEG]};

   //==================================================
   // Multiply
   //==================================================

   assign product = operand[PORT_MUL1] * operand[PORT_MUL2];
   assign mul_wr  = '{en: mul_op.en, index: mul_op.dest.index, data: product[26:0]};

   //==================================================
   // Add pipe
   //==================================================

   always_ff @(posedge clk) begin
      if (reset) begin
         add_valid <= 1'b0;
      end else begin
         add_valid <= add_op.en;
      end
   end

   // Sum and destination held for the write one edge later
   always_ff @(posedge clk) begin
      if (add_op.en) begin
         add_sum   <= operand[PORT_ADD1] + operand[PORT_ADD2];
         add_index <= add_op.dest.index;
      end
   end

   assign add_wr = '{en: add_valid, index: add_index, data: add_sum};

endmodule

/* hw/iteration_state.sv */
// Iteration state
// Holds z and magnitude, takes at most one special write per cycle in
// slot order load, negate, add, multiply, and strobes done once the
// magnitude reaches max_magnitude

module iteration_state
   import vliw_pkg::*;
#(
   parameter word_t max_magnitude = 300
) (
   input  logic  clk,
   input  logic  reset,
   input  wr_t   load_wr,
   input  wr_t   neg_wr,
   input  wr_t   add_wr,
   input  wr_t   mul_wr,
   output z_t    z,
   output word_t magnitude,
   output logic  done
);

   wr_t slot_wr [4];
   wr_t spec_wr;

   assign slot_wr = '{load_wr, neg_wr, add_wr, mul_wr};

   //==================================================
   // Special write priority
   //==================================================

   // Scan from the last slot so the first one wins
   always_comb begin
      spec_wr = '0;
      for (int i = 3; i >= 0; i--) begin
         if (slot_wr[i].en && slot_wr[i].index <= IDX_MAG) begin
            spec_wr = slot_wr[i];
         end
      end
   end

   //==================================================
   // Registers and escape strobe
   //==================================================

   // Cleared while done is high, so done lasts two cycles
   always_ff @(posedge clk) begin
      if (reset || done) begin
         z         <= '0;
         magnitude <= '0;
      end else if (spec_wr.en) begin
         case (spec_wr.index)
            IDX_Z_RE: z.re <= spec_wr.data;
            IDX_Z_IM: z.im <= spec_wr.data;
            default:  magnitude <= spec_wr.data;
         endcase
      end
   end

   // Signed compare of the registered magnitude
   always_ff @(posedge clk) begin
      if (reset) begin
         done <= 1'b0;
      end else begin
         done <= (magnitude >= max_magnitude);
      end
   end

endmodule

/* hw/regfile/operand_select.sv */
// Operand selection for the five read ports
// Entries 0 to 2 of any bank read z and magnitude instead of the bank.
// Every other index returns the word of the addressed bank.

module operand_select
   import vliw_pkg::*;
(
   input  addr_t      src [NUM_RD],
   input  word_t      bank_data [4][NUM_RD],
   input  z_t         z,
   input  word_t      magnitude,
   output logic [7:0] rd_index [NUM_RD],
   output word_t      operand [NUM_RD]
);

   //==================================================
   // Bank read indices
   //==================================================

   // Same index goes to all four banks, the bank bits pick the result
   always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
         rd_index[p] = src[p].index;
      end
   end

   //==================================================
   // Operand mux
   //==================================================

   always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
         case (src[p].index)
            IDX_Z_RE: begin
               operand[p] = z.re;
            end
            IDX_Z_IM: begin
               operand[p] = z.im;
            end
            IDX_MAG: begin
               operand[p] = magnitude;
            end
            default: begin
               operand[p] = bank_data[src[p].bank][p];
            end
         endcase
      end
   end

endmodule

/* hw/regfile/result_bank.sv */
// Result bank of one execution slot
// 256 words, written by its own slot at the clock edge and read
// combinationally by all five operand ports

module result_bank
   import vliw_pkg::*;
(
   input  logic       clk,
   input  wr_t        wr,
   input  logic [7:0] rd_index [NUM_RD],
   output word_t      rd_data [NUM_RD]
);

   //==================================================
   // Storage
   //==================================================

   word_t mem [256];

   // Single write port, index only, bank bits already dropped
   always_ff @(posedge clk) begin
      if (wr.en) begin
         mem[wr.index] <= wr.data;
      end
   end

   //==================================================
   // Read ports
   //==================================================

   // One port per reader, no read latency
   always_comb begin
      for (int p = 0; p < NUM_RD; p++) begin
         rd_data[p] = mem[rd_index[p]];
      end
   end

endmodule

/* hw/vliw_core.sv */
// VLIW core for escape-time iteration
// Issues one bundle per cycle with optional load, negate, add and
// multiply operations. Each slot writes its own result bank, and the
// z and magnitude registers drive the escape strobe.

module vliw_core
   import vliw_pkg::*;
#(
   parameter word_t max_magnitude = 300
) (
   input  logic     clk,
   input  logic     reset,
   input  load_op_t load_op,
   input  neg_op_t  neg_op,
   input  bin_op_t  add_op,
   input  bin_op_t  mul_op,
   output z_t       z,
   output logic     done
);

   //==================================================
   // Internal signals
   //==================================================

   addr_t      src [NUM_RD];
   logic [7:0] rd_index [NUM_RD];
   word_t      bank_data [4][NUM_RD];
   word_t      operand [NUM_RD];
   word_t      magnitude;

   wr_t load_wr;
   wr_t neg_wr;
   wr_t add_wr;
   wr_t mul_wr;
   wr_t bank_wr [4];

   // Source address of every read port
   always_comb begin
      src[PORT_NEG]  = neg_op.src;
      src[PORT_ADD1] = add_op.src1;
      src[PORT_ADD2] = add_op.src2;
      src[PORT_MUL1] = mul_op.src1;
      src[PORT_MUL2] = mul_op.src2;
   end

   // Each slot owns one bank
   always_comb begin
      bank_wr[BANK_LOAD] = load_wr;
      bank_wr[BANK_NEG]  = neg_wr;
      bank_wr[BANK_ADD]  = add_wr;
      bank_wr[BANK_MUL]  = mul_wr;
   end

   //==================================================
   // Result banks
   //==================================================

   for (genvar b = 0; b < 4; b++) begin : g_bank
      result_bank bank_i (
         .clk      (clk),
         .wr       (bank_wr[b]),
         .rd_index (rd_index),
         .rd_data  (bank_data[b])
      );
   end

   operand_select operand_select_i (
      .src       (src),
      .bank_data (bank_data),
      .z         (z),
      .magnitude (magnitude),
      .rd_index  (rd_index),
      .operand   (operand)
   );

   exec_slots exec_slots_i (
      .clk     (clk),
      .reset   (reset),
      .load_op (load_op),
      .neg_op  (neg_op),
      .add_op  (add_op),
      .mul_op  (mul_op),
      .operand (operand),
      .load_wr (load_wr),
      .neg_wr  (neg_wr),
      .add_wr  (add_wr),
      .mul_wr  (mul_wr)
   );

   iteration_state #(
      .max_magnitude (max_magnitude)
   ) iteration_state_i (
      .clk       (clk),
      .reset     (reset),
      .load_wr   (load_wr),
      .neg_wr    (neg_wr),
      .add_wr    (add_wr),
      .mul_wr    (mul_wr),
      .z         (z),
      .magnitude (magnitude),
      .done      (done)
   );

endmodule

/* sources.f */
common/vliw_pkg.sv
hw/regfile/result_bank.sv
hw/regfile/operand_select.sv
hw/exec_slots.sv
hw/iteration_state.sv
hw/vliw_core.sv
verif/vliw_props.sv
verif/vliw_checker.sv
verif/vliw_tb.sv

/* verif/vliw_checker.sv */
// Reference model and scoreboard for the VLIW core
// Mirrors the four result banks, z, magnitude, the add pipe and done,
// and compares z and done at every rising edge

module vliw_checker
   import vliw_pkg::*;
#(
   parameter int max_magnitude = 300
) (
   input  logic     clk,
   input  logic     reset,
   input  load_op_t load_op,
   input  neg_op_t  neg_op,
   input  bin_op_t  add_op,
   input  bin_op_t  mul_op,
   input  z_t       z,
   input  logic     done,
   output int       checks,
   output int       z_errors,
   output int       done_errors
);
   timeunit 1ns;
   timeprecision 1ps;

   word_t      bank_m [4][256];
   z_t         z_m;
   word_t      mag_m;
   logic       done_m;
   logic       add_valid_m;
   logic [7:0] add_index_m;
   word_t      add_sum_m;
   logic       armed;

   initial begin
      checks = 0;
      z_errors = 0;
      done_errors = 0;
      armed = 1'b0;
      done_m = 1'b0;
      add_valid_m = 1'b0;
      z_m = '0;
      mag_m = '0;
   end

   // Keep the low 27 bits, two's complement wrap
   function automatic word_t low_bits(longint v);
      return v[26:0];
   endfunction

   function automatic word_t read_operand(addr_t a);
      if (a.index == 8'd0) return z_m.re;
      else if (a.index == 8'd1) return z_m.im;
      else if (a.index == 8'd2) return mag_m;
      return bank_m[a.bank][a.index];
   endfunction

   //==================================================
   // Compare, then step the model
   //==================================================

   always @(posedge clk) begin : model
      wr_t   slot [4];
      wr_t   spec;
      word_t add_res;
      logic  done_next;
      if (armed) begin
         checks++;
         if (z !== z_m) begin
            z_errors++;
            $display("error at %0t ns: z expected re=%0d im=%0d, got re=%0d im=%0d",
                     $time, z_m.re, z_m.im, z.re, z.im);
         end
         if (done !== done_m) begin
            done_errors++;
            $display("error at %0t ns: done expected %b, got %b", $time, done_m, done);
         end
      end
      // All operands read from the state before this edge
      slot[0] = '{en: load_op.en, index: load_op.dest.index, data: load_op.value};
      slot[1] = '{en: neg_op.en, index: neg_op.dest.index,
                  data: low_bits(-longint'(read_operand(neg_op.src)))};
      slot[2] = '{en: add_valid_m, index: add_index_m, data: add_sum_m};
      slot[3] = '{en: mul_op.en, index: mul_op.dest.index,
                  data: low_bits(longint'(read_operand(mul_op.src1)) *
                                 longint'(read_operand(mul_op.src2)))};
      add_res = low_bits(longint'(read_operand(add_op.src1)) +
                         longint'(read_operand(add_op.src2)));
      spec = '0;
      for (int i = 0; i < 4; i++) begin
         if (!spec.en && slot[i].en && slot[i].index < 8'd3) begin
            spec = slot[i];
         end
      end
      done_next = !reset && (int'(mag_m) >= max_magnitude);
      if (reset || done_m) begin
         z_m = '0;
         mag_m = '0;
      end else if (spec.en) begin
         if (spec.index == 8'd0) z_m.re = spec.data;
         else if (spec.index == 8'd1) z_m.im = spec.data;
         else mag_m = spec.data;
      end
      // Slot order matches bank order
      for (int b = 0; b < 4; b++) begin
         if (slot[b].en) bank_m[b][slot[b].index] = slot[b].data;
      end
      add_valid_m = !reset && add_op.en;
      if (add_op.en) begin
         add_sum_m = add_res;
         add_index_m = add_op.dest.index;
      end
      done_m = done_next;
      if (reset) armed = 1'b1;
   end

endmodule

/* verif/vliw_props.sv */
// Escape strobe properties
// Bound into iteration_state, covers reset, the z clear and the
// two-cycle length of done

module vliw_props
   import vliw_pkg::*;
(
   input logic clk,
   input logic reset,
   input z_t   z,
   input logic done
);
   timeunit 1ns;
   timeprecision 1ps;

   done_low_after_reset: assert property (@(posedge clk) reset |=> !done)
      else $error("done high in the cycle after reset");

   z_clear_after_done: assert property (@(posedge clk) disable iff (reset)
      done |=> (z == '0))
      else $error("z not cleared after a done cycle");

   // Third cycle of done would mean the clear did not reach magnitude
   done_two_cycles: assert property (@(posedge clk) disable iff (reset)
      ($past(done) && done) |=> !done)
      else $error("done high for more than two cycles");

endmodule

bind iteration_state vliw_props props_i (
   .clk   (clk),
   .reset (reset),
   .z     (z),
   .done  (done)
);

/* verif/vliw_tb.sv */
// Testbench for the VLIW core
// Directed sequences for load, negate, multiply, the add pipe, slot
// priority and the escape strobe, then LCG-driven random bundles

module vliw_tb
   import vliw_pkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MAX_MAG = 300;
   localparam int RANDOM_BUNDLES = 4000;

   logic        clk = 1'b0;
   logic        reset;
   load_op_t    load_op;
   neg_op_t     neg_op;
   bin_op_t     add_op;
   bin_op_t     mul_op;
   z_t          z;
   logic        done;
   int          checks;
   int          z_errors;
   int          done_errors;
   int          directed_errors = 0;
   int          timeouts = 0;
   int          high_cycles;
   logic [31:0] lcg_state = 32'd20853;
   word_t       sq;
   addr_t       a7;
   addr_t       a8;

   always #4 clk = ~clk;

   vliw_core #(.max_magnitude(word_t'(MAX_MAG))) vliw_core_i (
      .clk (clk), .reset (reset), .load_op (load_op), .neg_op (neg_op),
      .add_op (add_op), .mul_op (mul_op), .z (z), .done (done)
   );

   vliw_checker #(.max_magnitude(MAX_MAG)) checker_i (
      .clk (clk), .reset (reset), .load_op (load_op), .neg_op (neg_op),
      .add_op (add_op), .mul_op (mul_op), .z (z), .done (done),
      .checks (checks), .z_errors (z_errors), .done_errors (done_errors)
   );

   //==================================================
   // Stimulus helpers
   //==================================================

   // Upper half of the LCG state since the low bits cycle too fast
   function automatic int next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return int'(lcg_state[31:16]);
   endfunction

   function automatic word_t small_value();
      return word_t'(next_rand() % 1024 - 512);
   endfunction

   // Specials about one time in five and otherwise a small pool of entries
   function automatic logic [7:0] pick_index();
      int r;
      r = next_rand() % 16;
      if (r < 3) return 8'(r);
      return 8'(3 + next_rand() % 12);
   endfunction

   function automatic addr_t make_addr(logic [1:0] bank, logic [7:0] index);
      return '{bank: bank, index: index};
   endfunction

   function automatic addr_t random_addr();
      return make_addr(2'(next_rand()), pick_index());
   endfunction

   task automatic cycle();
      @(negedge clk);
      load_op = '0;
      neg_op = '0;
      add_op = '0;
      mul_op = '0;
   endtask

   task automatic load(word_t data, logic [7:0] index);
      load_op = '{en: 1'b1, value: data, dest: make_addr(BANK_LOAD, index)};
   endtask

   task automatic negate(addr_t a, logic [7:0] index);
      neg_op = '{en: 1'b1, src: a, dest: make_addr(BANK_NEG, index)};
   endtask

   task automatic add_pair(addr_t a, addr_t b, logic [7:0] index);
      add_op = '{en: 1'b1, src1: a, src2: b, dest: make_addr(BANK_ADD, index)};
   endtask

   task automatic multiply(addr_t a, addr_t b, logic [7:0] index);
      mul_op = '{en: 1'b1, src1: a, src2: b, dest: make_addr(BANK_MUL, index)};
   endtask

   task automatic random_bundle();
      if (next_rand() % 4 != 0) begin
         if (next_rand() % 16 == 0) load(word_t'(next_rand() * 2048), pick_index());
         else load(small_value(), pick_index());
      end
      if (next_rand() % 2 != 0) negate(random_addr(), pick_index());
      if (next_rand() % 2 != 0) add_pair(random_addr(), random_addr(), pick_index());
      if (next_rand() % 2 != 0) multiply(random_addr(), random_addr(), pick_index());
   endtask

   //==================================================
   // Directed checks
   //==================================================

   task automatic check_z(word_t re, word_t im);
      if (z.re !== re) begin
         directed_errors++;
         $display("error at %0t ns: z.re expected %0d, got %0d", $time, re, z.re);
      end
      if (z.im !== im) begin
         directed_errors++;
         $display("error at %0t ns: z.im expected %0d, got %0d", $time, im, z.im);
      end
   endtask

   task automatic expect_done_low(int cycles);
      repeat (cycles) begin
         cycle();
         if (done !== 1'b0) begin
            directed_errors++;
            $display("error at %0t ns: done expected 0, got %b", $time, done);
         end
      end
   endtask

   task automatic wait_done(int limit);
      int n;
      n = 0;
      while (done !== 1'b1 && n < limit) begin
         cycle();
         n++;
      end
      if (done !== 1'b1) begin
         timeouts++;
         $display("done did not rise within %0d cycles at %0t ns", limit, $time);
      end
   endtask

   initial begin
      reset = 1'b1;
      load_op = '0;
      neg_op = '0;
      add_op = '0;
      mul_op = '0;
      a7 = make_addr(BANK_LOAD, 8'd7);
      a8 = make_addr(BANK_LOAD, 8'd8);
      repeat (2) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;

      // Fill every entry above the specials in all four banks
      for (int i = 3; i < 256; i++) begin
         load(small_value(), 8'(i));
         cycle();
      end
      for (int i = 3; i < 256; i++) begin
         negate(make_addr(BANK_LOAD, 8'(i)), 8'(i));
         add_pair(make_addr(BANK_LOAD, 8'(i)), make_addr(BANK_LOAD, 8'(i)), 8'(i));
         multiply(make_addr(BANK_LOAD, 8'(i)), make_addr(BANK_LOAD, 8'(i)), 8'(i));
         cycle();
      end
      cycle();

      // Loads into the specials
      load(27'sd37, IDX_Z_RE);
      cycle();
      load(-27'sd12, IDX_Z_IM);
      cycle();
      check_z(27'sd37, -27'sd12);
      load(word_t'(MAX_MAG - 1), IDX_MAG);
      cycle();
      expect_done_low(4);

      // Negate and multiply from a bank-0 entry with a wrapping square
      load(27'sd20000, 8'd5);
      cycle();
      negate(make_addr(BANK_LOAD, 8'd5), IDX_Z_RE);
      cycle();
      multiply(make_addr(BANK_LOAD, 8'd5), make_addr(BANK_LOAD, 8'd5), IDX_Z_IM);
      cycle();
      sq = word_t'(64'sd20000 * 64'sd20000);
      check_z(-27'sd20000, sq);
      load(27'sh4000000, 8'd6);
      cycle();
      negate(make_addr(BANK_LOAD, 8'd6), IDX_Z_RE);
      cycle();
      check_z(27'sh4000000, sq);

      // Add lands two cycles after issue
      load(27'sd100, 8'd7);
      cycle();
      load(27'sd23, 8'd8);
      cycle();
      add_pair(a7, a8, IDX_Z_RE);
      cycle();
      check_z(27'sh4000000, sq);
      cycle();
      check_z(27'sd123, sq);
      add_pair(a7, a7, IDX_Z_RE);
      cycle();
      add_pair(a8, a8, IDX_Z_RE);
      cycle();
      check_z(27'sd200, sq);
      cycle();
      check_z(27'sd46, sq);

      // Slot priority on a shared special destination
      load(27'sd11, IDX_Z_RE);
      negate(a7, IDX_Z_RE);
      add_pair(a7, a8, IDX_Z_RE);
      multiply(a7, a8, IDX_Z_RE);
      cycle();
      check_z(27'sd11, sq);
      negate(a7, IDX_Z_RE);
      add_pair(a7, a8, IDX_Z_RE);
      multiply(a7, a8, IDX_Z_RE);
      cycle();
      check_z(-27'sd100, sq);
      cycle();
      check_z(27'sd123, sq);

      // Escape at max_magnitude
      load(word_t'(MAX_MAG), IDX_MAG);
      cycle();
      wait_done(8);
      high_cycles = 0;
      while (done === 1'b1 && high_cycles < 8) begin
         cycle();
         high_cycles++;
      end
      if (high_cycles != 2) begin
         directed_errors++;
         $display("done stayed high for %0d cycles instead of two at %0t ns",
                  high_cycles, $time);
      end
      check_z(27'sd0, 27'sd0);
      // A cleared magnitude plus 100 gives 100
      add_pair(make_addr(BANK_LOAD, IDX_MAG), a7, IDX_Z_IM);
      cycle();
      cycle();
      check_z(27'sd0, 27'sd100);
      load(word_t'(MAX_MAG - 1), IDX_MAG);
      cycle();
      expect_done_low(4);

      for (int n = 0; n < RANDOM_BUNDLES; n++) begin
         random_bundle();
         cycle();
      end
      repeat (4) cycle();

      $display("checks %0d, z errors %0d, done errors %0d, directed errors %0d, timeouts %0d",
               checks, z_errors, done_errors, directed_errors, timeouts);
      if (z_errors + done_errors + directed_errors + timeouts == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
